/* verilog/his_pkg.sv */
package his_pkg;

    // array dimensions

    // bins in one pixel histogram
    localparam int BIN_NUM = 16;
    // pixels held in each bank
    localparam int PIXEL_NUM = 4;
    // events per pixel in one acquisition
    localparam int DATA_NUM = 4;
    // acquisitions that make up a frame
    localparam int ACQ_NUM = 2;

    // output flow control

    // credits held by the readout after reset
    localparam int CREDIT_MAX = 4;

    // counter width

    // one bin sees at most DATA_NUM * ACQ_NUM hits per frame
    localparam int COUNT_W = 8;

    // shared vector types

    // timing bin index from the front end
    typedef logic [3:0] bin_t;

    // pixel index inside a bank
    typedef logic [1:0] pixel_t;

    // per-bin photon count
    typedef logic [COUNT_W-1:0] count_t;

    // output credits, must reach CREDIT_MAX
    typedef logic [2:0] credit_t;

endpackage

/* verilog/his_sequencer.sv */
module his_sequencer (
    input  logic              clk,
    input  logic              combin_res,
    // event handshake from the converter
    input  logic              event_valid,
    output logic              event_ready,
    // readout still emptying the previous bank
    input  logic              drain_busy,
    // write side of the bin memory
    output logic              wr_en,
    output his_pkg::pixel_t   wr_pixel,
    // bank that is accumulating
    output logic              his_num,
    // end of frame pulses
    output logic              swap,
    output logic              frame_done
);

    // counter types sized from the package dimensions
    typedef logic [$clog2(his_pkg::DATA_NUM)-1:0] evt_cnt_t;
    typedef logic [$clog2(his_pkg::ACQ_NUM)-1:0]  acq_cnt_t;

    evt_cnt_t         evt_cnt;
    his_pkg::pixel_t  pixel_cnt;
    acq_cnt_t         acq_cnt;

    logic             evt_wrap;
    logic             pixel_wrap;
    logic             acq_wrap;
    logic             last_event;
    logic             frame_end;

    // wrap conditions of the three nested counters
    assign evt_wrap   = (evt_cnt == evt_cnt_t'(his_pkg::DATA_NUM - 1));
    assign pixel_wrap = (pixel_cnt == his_pkg::pixel_t'(his_pkg::PIXEL_NUM - 1));
    assign acq_wrap   = (acq_cnt == acq_cnt_t'(his_pkg::ACQ_NUM - 1));

    // 32nd event of the frame
    assign last_event = evt_wrap && pixel_wrap && acq_wrap;

    // hold the closing event until the other bank is empty
    // otherwise the swap would hand a half drained bank to the writer
    assign event_ready = !(last_event && drain_busy);

    // accepted event goes straight to the memory
    assign wr_en    = event_valid && event_ready;
    assign wr_pixel = pixel_cnt;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            evt_cnt   <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
            his_num   <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            // pulse by default
            frame_end <= 1'b0;
            if (wr_en) begin
                if (!evt_wrap) begin
                    evt_cnt <= evt_cnt + 1'b1;
                end else begin
                    evt_cnt <= '0;
                    // next pixel after DATA_NUM events
                    if (!pixel_wrap) begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                    end else begin
                        pixel_cnt <= '0;
                        // next acquisition after all pixels
                        if (!acq_wrap) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            acq_cnt   <= '0;
                            // frame complete, flip banks
                            his_num   <= ~his_num;
                            frame_end <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // one register drives both frame pulses
    assign swap       = frame_end;
    assign frame_done = frame_end;

endmodule

/* verilog/his_bin_memory.sv */
module his_bin_memory (
    input  logic              clk,
    input  logic              combin_res,
    // increment port, bank given by the sequencer
    input  logic              wr_en,
    input  logic              wr_bank,
    input  his_pkg::pixel_t   wr_pixel,
    input  his_pkg::bin_t     wr_bin,
    // clear-on-read port, always the other bank
    input  logic              rd_en,
    input  his_pkg::pixel_t   rd_pixel,
    input  his_pkg::bin_t     rd_bin,
    output his_pkg::count_t   rd_count,
    // new count after each increment
    output logic              upd_valid,
    output his_pkg::count_t   upd_count
);

    // two banks of PIXEL_NUM histograms, BIN_NUM bins each
    his_pkg::count_t mem [2][his_pkg::PIXEL_NUM][his_pkg::BIN_NUM];

    logic            rd_bank;
    his_pkg::count_t wr_old;
    his_pkg::count_t wr_sum;

    // readout works on the finished bank
    assign rd_bank = ~wr_bank;

    // async read of the bin being hit
    assign wr_old = mem[wr_bank][wr_pixel][wr_bin];
    assign wr_sum = wr_old + 1'b1;

    // async read for the readout
    assign rd_count = mem[rd_bank][rd_pixel][rd_bin];

    // banks never collide, write and clear hit different halves
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            // start with empty histograms in both banks
            for (int b = 0; b < 2; b++) begin
                for (int p = 0; p < his_pkg::PIXEL_NUM; p++) begin
                    for (int n = 0; n < his_pkg::BIN_NUM; n++) begin
                        mem[b][p][n] <= '0;
                    end
                end
            end
        end else begin
            // read-modify-write in one cycle
            if (wr_en) begin
                mem[wr_bank][wr_pixel][wr_bin] <= wr_sum;
            end
            // drained word is zeroed for the next frame
            if (rd_en) begin
                mem[rd_bank][rd_pixel][rd_bin] <= '0;
            end
        end
    end

    // update strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= wr_en;
        end
    end

    // update payload, only meaningful with upd_valid
    always_ff @(posedge clk) begin
        if (wr_en) begin
            upd_count <= wr_sum;
        end
    end

endmodule

/* verilog/his_readout.sv */
module his_readout (
    input  logic              clk,
    input  logic              combin_res,
    // start of drain from the sequencer
    input  logic              swap,
    // one credit back from the sink
    input  logic              out_credit,
    // word from the finished bank
    input  his_pkg::count_t   rd_count,
    // high while the finished bank is being emptied
    output logic              drain_busy,
    // read and clear request into the memory
    output logic              rd_en,
    output his_pkg::pixel_t   rd_pixel,
    output his_pkg::bin_t     rd_bin,
    // histogram word stream
    output logic              hist_valid,
    output his_pkg::pixel_t   hist_pixel,
    output his_pkg::bin_t     hist_bin,
    output his_pkg::count_t   hist_count,
    output logic              hist_last
);

    his_pkg::credit_t credit;
    his_pkg::credit_t credit_nxt;
    logic             active;
    logic             rd_last_bin;
    logic             rd_last;

    // end of a pixel and end of the bank
    assign rd_last_bin = (rd_bin == his_pkg::bin_t'(his_pkg::BIN_NUM - 1));
    assign rd_last     = rd_last_bin &&
                         (rd_pixel == his_pkg::pixel_t'(his_pkg::PIXEL_NUM - 1));

    // first word goes in the swap cycle itself
    // no word leaves without a credit in hand
    assign rd_en = (swap || active) && (credit != '0);

    // spend on read, refill on return pulse
    always_comb begin
        credit_nxt = credit;
        if (rd_en) begin
            credit_nxt = credit_nxt - 1'b1;
        end
        if (out_credit) begin
            credit_nxt = credit_nxt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            credit     <= his_pkg::credit_t'(his_pkg::CREDIT_MAX);
            active     <= 1'b0;
            drain_busy <= 1'b0;
            rd_pixel   <= '0;
            rd_bin     <= '0;
            hist_valid <= 1'b0;
            hist_last  <= 1'b0;
        end else begin
            credit <= credit_nxt;
            // scan runs until the last address is read
            if (rd_en && rd_last) begin
                active <= 1'b0;
            end else if (swap) begin
                active <= 1'b1;
            end
            // busy until the final word has left
            if (swap) begin
                drain_busy <= 1'b1;
            end else if (hist_valid && hist_last) begin
                drain_busy <= 1'b0;
            end
            // bins inside a pixel, then next pixel
            if (rd_en) begin
                if (rd_last_bin) begin
                    rd_bin   <= '0;
                    // pixel index rolls over to 0 after the last pixel
                    rd_pixel <= rd_pixel + 1'b1;
                end else begin
                    rd_bin <= rd_bin + 1'b1;
                end
            end
            hist_valid <= rd_en;
            hist_last  <= rd_en && rd_last;
        end
    end

    // word payload follows the read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            hist_pixel <= rd_pixel;
            hist_bin   <= rd_bin;
            hist_count <= rd_count;
        end
    end

endmodule

/* verilog/his_top.sv */
module his_top (
    input  logic              clk,
    input  logic              combin_res,
    // photon events from the converter
    input  logic              event_valid,
    input  his_pkg::bin_t     event_bin,
    output logic              event_ready,
    // credit return from the sink
    input  logic              out_credit,
    // per-event update report
    output logic              upd_valid,
    output his_pkg::count_t   upd_count,
    // frame status
    output logic              frame_done,
    output logic              his_num,
    // histogram stream
    output logic              hist_valid,
    output his_pkg::pixel_t   hist_pixel,
    output his_pkg::bin_t     hist_bin,
    output his_pkg::count_t   hist_count,
    output logic              hist_last
);

    // sequencer to memory
    logic             wr_en;
    his_pkg::pixel_t  wr_pixel;

    // sequencer and readout
    logic             swap;
    logic             drain_busy;

    // readout to memory
    logic             rd_en;
    his_pkg::pixel_t  rd_pixel;
    his_pkg::bin_t    rd_bin;
    his_pkg::count_t  rd_count;

    // event counting and bank select
    his_sequencer u_sequencer (
        .clk         (clk),
        .combin_res  (combin_res),
        .event_valid (event_valid),
        .drain_busy  (drain_busy),
        .event_ready (event_ready),
        .wr_en       (wr_en),
        .wr_pixel    (wr_pixel),
        .his_num     (his_num),
        .swap        (swap),
        .frame_done  (frame_done)
    );

    // write bank is his_num, read bank the other one
    his_bin_memory u_bin_memory (
        .clk         (clk),
        .combin_res  (combin_res),
        .wr_en       (wr_en),
        .wr_bank     (his_num),
        .wr_pixel    (wr_pixel),
        .wr_bin      (event_bin),
        .rd_en       (rd_en),
        .rd_pixel    (rd_pixel),
        .rd_bin      (rd_bin),
        .rd_count    (rd_count),
        .upd_valid   (upd_valid),
        .upd_count   (upd_count)
    );

    // drains the finished bank under credits
    his_readout u_readout (
        .clk         (clk),
        .combin_res  (combin_res),
        .swap        (swap),
        .out_credit  (out_credit),
        .rd_count    (rd_count),
        .drain_busy  (drain_busy),
        .rd_en       (rd_en),
        .rd_pixel    (rd_pixel),
        .rd_bin      (rd_bin),
        .hist_valid  (hist_valid),
        .hist_pixel  (hist_pixel),
        .hist_bin    (hist_bin),
        .hist_count  (hist_count),
        .hist_last   (hist_last)
    );

endmodule

/* test/his_sva.sv */
module his_sva (
    input logic              clk,
    input logic              combin_res,
    input logic              hist_valid,
    input logic              frame_done,
    input logic              his_num,
    input logic              event_ready,
    input logic              drain_busy,
    input his_pkg::credit_t  credit
);

    // every word was read with a credit in hand
    a_credit_held: assert property (@(posedge clk) disable iff (!combin_res)
        hist_valid |-> $past(credit) != '0
    ) else $error("hist_valid without a credit held");

    // end of frame lasts one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |=> !frame_done
    ) else $error("frame_done longer than one cycle");

    // bank flips only at end of frame
    a_bank_flip: assert property (@(posedge clk) disable iff (!combin_res)
        (his_num != $past(his_num)) |-> frame_done
    ) else $error("his_num changed without frame_done");

    // stall only while the other bank drains
    a_stall_cause: assert property (@(posedge clk) disable iff (!combin_res)
        !drain_busy |-> event_ready
    ) else $error("event_ready low with drain idle");

endmodule

bind his_top his_sva u_sva (
    .clk         (clk),
    .combin_res  (combin_res),
    .hist_valid  (hist_valid),
    .frame_done  (frame_done),
    .his_num     (his_num),
    .event_ready (event_ready),
    .drain_busy  (drain_busy),
    .credit      (u_readout.credit)
);

/* test/his_tb.sv */
module his_tb;

    // frame and readout sizes from the array dimensions
    localparam int FRAME_EVENTS = his_pkg::DATA_NUM * his_pkg::PIXEL_NUM * his_pkg::ACQ_NUM;
    localparam int READ_WORDS   = his_pkg::PIXEL_NUM * his_pkg::BIN_NUM;
    // four frames, about three cycles per event, slow credit release while draining
    localparam int TEST_CYCLES  = 10 + 4 * (3 * FRAME_EVENTS + 4 * READ_WORDS);
    localparam int CYCLE_LIMIT  = 4 * TEST_CYCLES;

    logic              clk;
    logic              combin_res;
    logic              event_valid;
    his_pkg::bin_t     event_bin;
    logic              event_ready;
    logic              out_credit = 1'b0;
    logic              upd_valid;
    his_pkg::count_t   upd_count;
    logic              frame_done;
    logic              his_num;
    logic              hist_valid;
    his_pkg::pixel_t   hist_pixel;
    his_pkg::bin_t     hist_bin;
    his_pkg::count_t   hist_count;
    logic              hist_last;

    // reference histograms, one per bank
    int                model [2][his_pkg::PIXEL_NUM][his_pkg::BIN_NUM];
    logic              acc_bank;
    int                frame_event;
    int                seed = 35292;
    int                errors;
    int                checks;
    int                cycle;

    // sink state and captured words
    logic              hold_credits;
    int                words_seen;
    int                credits_returned;
    int                grants_given;
    int                grants_used;
    int                rd_ptr;
    his_pkg::pixel_t   q_pixel [$];
    his_pkg::bin_t     q_bin [$];
    his_pkg::count_t   q_count [$];
    logic              q_last [$];

    his_top u_dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .event_valid (event_valid),
        .event_bin   (event_bin),
        .event_ready (event_ready),
        .out_credit  (out_credit),
        .upd_valid   (upd_valid),
        .upd_count   (upd_count),
        .frame_done  (frame_done),
        .his_num     (his_num),
        .hist_valid  (hist_valid),
        .hist_pixel  (hist_pixel),
        .hist_bin    (hist_bin),
        .hist_count  (hist_count),
        .hist_last   (hist_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit
    initial begin
        cycle = 0;
        while (cycle < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycle);
        $display("Testbench failed");
        $finish;
    end

    // words captured mid-cycle
    always @(negedge clk) begin
        if (combin_res && hist_valid) begin
            q_pixel.push_back(hist_pixel);
            q_bin.push_back(hist_bin);
            q_count.push_back(hist_count);
            q_last.push_back(hist_last);
            words_seen++;
        end
    end

    // one credit back per cycle, gated by grants while withheld
    always @(posedge clk) begin
        out_credit <= 1'b0;
        if (combin_res && words_seen > credits_returned) begin
            if (!hold_credits || grants_used < grants_given) begin
                out_credit <= 1'b1;
                credits_returned++;
                if (hold_credits) begin
                    grants_used++;
                end
            end
        end
    end

    task automatic check_count(string name, his_pkg::count_t exp, his_pkg::count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_pixel(string name, his_pkg::pixel_t exp, his_pkg::pixel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected pixel %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bin(string name, his_pkg::bin_t exp, his_pkg::bin_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected bin %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
        end
    endtask

    // present one event, held by the source until accepted
    task automatic begin_event(his_pkg::bin_t b);
        @(posedge clk);
        event_valid <= 1'b1;
        event_bin   <= b;
    endtask

    // acceptance, then update report and frame status one cycle later
    task automatic finish_event(his_pkg::bin_t b, string name);
        int   pix;
        logic bank;
        logic last;
        // pixel steps every DATA_NUM events, wraps each acquisition
        pix  = (frame_event / his_pkg::DATA_NUM) % his_pkg::PIXEL_NUM;
        bank = acc_bank;
        @(negedge clk);
        while (!event_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        event_valid <= 1'b0;
        model[bank][pix][b] += 1;
        frame_event++;
        last = (frame_event == FRAME_EVENTS);
        if (last) begin
            frame_event = 0;
            acc_bank    = ~acc_bank;
        end
        @(negedge clk);
        check_bit(name, 1'b1, upd_valid);
        check_count(name, his_pkg::count_t'(model[bank][pix][b]), upd_count);
        check_bit(name, last, frame_done);
        check_bit(name, acc_bank, his_num);
    endtask

    // random bins, mask narrows the range to force repeats
    task automatic send_random(int n, his_pkg::bin_t mask, string name);
        his_pkg::bin_t b;
        for (int i = 0; i < n; i++) begin
            b = his_pkg::bin_t'($random(seed)) & mask;
            begin_event(b);
            finish_event(b, name);
        end
    endtask

    // 64 words, pixel then bin order, last flag on the final one
    task automatic check_frame(string name, int bank);
        int pix;
        int bin;
        while (q_count.size() - rd_ptr < READ_WORDS) begin
            @(negedge clk);
        end
        for (int i = 0; i < READ_WORDS; i++) begin
            pix = i / his_pkg::BIN_NUM;
            bin = i % his_pkg::BIN_NUM;
            check_pixel(name, his_pkg::pixel_t'(pix), q_pixel[rd_ptr]);
            check_bin(name, his_pkg::bin_t'(bin), q_bin[rd_ptr]);
            check_count(name, his_pkg::count_t'(model[bank][pix][bin]), q_count[rd_ptr]);
            check_bit(name, i == READ_WORDS - 1, q_last[rd_ptr]);
            // word is cleared as it is read
            model[bank][pix][bin] = 0;
            rd_ptr++;
        end
        // sink settles so the next frame starts with full credits
        while (!hold_credits && credits_returned < words_seen) begin
            @(negedge clk);
        end
    endtask

    task automatic reset_state();
        @(negedge clk);
        check_bit("reset_state", 1'b0, hist_valid);
        check_bit("reset_state", 1'b0, upd_valid);
        check_bit("reset_state", 1'b0, frame_done);
        check_bit("reset_state", 1'b0, his_num);
        check_bit("reset_state", 1'b1, event_ready);
    endtask

    task automatic frame_readout();
        // rest of frame one, then drain of bank 0
        send_random(FRAME_EVENTS - frame_event, 4'hf, "frame_readout");
        check_frame("frame_readout", 0);
    endtask

    task automatic credit_backpressure();
        hold_credits = 1'b1;
        grants_given = grants_used;
        send_random(FRAME_EVENTS, 4'hf, "credit_backpressure");
        repeat (20) @(negedge clk);
        check_count("credit_backpressure", his_pkg::count_t'(his_pkg::CREDIT_MAX),
                    his_pkg::count_t'(q_count.size() - rd_ptr));
        // single credits, one word each
        while (q_count.size() - rd_ptr < READ_WORDS) begin
            grants_given++;
            repeat (3) @(negedge clk);
        end
        hold_credits = 1'b0;
        check_frame("credit_backpressure", 1);
        repeat (8) @(negedge clk);
        check_count("credit_backpressure", '0, his_pkg::count_t'(q_count.size() - rd_ptr));
    endtask

    task automatic ping_pong_stall();
        his_pkg::bin_t b;
        hold_credits = 1'b1;
        grants_given = grants_used;
        // frame three parks in the readout after CREDIT_MAX words
        send_random(FRAME_EVENTS, 4'hf, "ping_pong_stall");
        send_random(FRAME_EVENTS - 1, 4'hf, "ping_pong_stall");
        // closing event of frame four waits for the drain
        b = his_pkg::bin_t'($random(seed));
        begin_event(b);
        repeat (4) @(negedge clk);
        check_bit("ping_pong_stall", 1'b0, event_ready);
        hold_credits = 1'b0;
        finish_event(b, "ping_pong_stall");
        check_bit("ping_pong_stall", 1'b1, event_ready);
        check_frame("ping_pong_stall", 0);
        check_frame("ping_pong_stall", 1);
    endtask

    initial begin
        combin_res   = 1'b0;
        event_valid  = 1'b0;
        event_bin    = '0;
        hold_credits = 1'b0;
        acc_bank     = 1'b0;
        repeat (10) @(posedge clk);
        combin_res <= 1'b1;
        reset_state();
        // partial frame, narrow bins so counts climb past one
        send_random(12, 4'h3, "update_counts");
        frame_readout();
        credit_backpressure();
        ping_pong_stall();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/his_pkg.sv
verilog/his_sequencer.sv
verilog/his_bin_memory.sv
verilog/his_readout.sv
verilog/his_top.sv
test/his_sva.sv
test/his_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= his_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

# pass only when the log holds the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
